// ==== common/rv_decode_pkg.sv ====
package rv_decode_pkg;

  // RV32 major opcodes
  typedef enum logic [6:0] {
    OPC_LUI     = 7'b0110111,
    OPC_AUIPC   = 7'b0010111,
    OPC_JAL     = 7'b1101111,
    OPC_JALR    = 7'b1100111,
    OPC_BRANCH  = 7'b1100011,
    OPC_LOAD    = 7'b0000011,
    OPC_STORE   = 7'b0100011,
    OPC_OP_IMM  = 7'b0010011,
    OPC_OP      = 7'b0110011,
    OPC_SYSTEM  = 7'b1110011,
    OPC_FENCE_I = 7'b0001111
  } opcode_e;

  // {inst[30], funct3}
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111,
    ALU_SUB  = 4'b1000,
    ALU_SRA  = 4'b1101
  } alu_op_e;

  // SYSTEM encodings
  localparam logic [2:0]  SYS_F3_PRIV = 3'b000;
  localparam logic [2:0]  SYS_F3_RSVD = 3'b100;
  localparam logic [11:0] SYS_ECALL   = 12'h000;
  localparam logic [11:0] SYS_MRET    = 12'h302;

  typedef struct packed {
    opcode_e     opcode;
    alu_op_e     alu_op;
    logic [31:0] op1;
    logic [31:0] op2;
    logic [31:0] imm;
    logic [3:0]  rd;
    logic        rd_we;
    logic        mem_ren;
    logic        mem_wen;
    logic [31:0] mem_addr;
    logic        jump_en;
    logic [31:0] jump_base;
    logic        is_system;
    logic        csr_wen;
    logic        illegal;
    logic [31:0] pc;
    logic [31:0] inst;
  } decode_out_t;

  // Execute-stage bypass
  typedef struct packed {
    logic        valid;
    logic [3:0]  rd;
    logic [31:0] data;
  } fwd_t;

  typedef struct packed {
    logic        valid;
    logic [3:0]  rd;
    logic [31:0] data;
  } wb_t;

  typedef struct packed {
    logic       valid;
    logic [3:0] rd;
  } sb_set_t;

endpackage

// ==== idu/imm_gen.sv ====
module imm_gen import rv_decode_pkg::*; (
  input  logic [31:0] inst_i,
  output logic [31:0] imm_o
);

  opcode_e opcode;

  assign opcode = opcode_e'(inst_i[6:0]);

  always_comb begin
    case (opcode)
      OPC_LUI, OPC_AUIPC: begin
        imm_o = {inst_i[31:12], 12'b0};
      end
      OPC_JAL: begin
        imm_o = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
      end
      OPC_JALR, OPC_LOAD, OPC_OP_IMM: begin
        imm_o = {{20{inst_i[31]}}, inst_i[31:20]};
      end
      OPC_STORE: begin
        imm_o = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
      end
      OPC_BRANCH: begin
        imm_o = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
      end
      OPC_SYSTEM: begin
        imm_o = {20'b0, inst_i[31:20]};  // CSR address, unsigned
      end
      default: begin
        imm_o = '0;
      end
    endcase
  end

endmodule

// ==== idu/idu_stage.sv ====
module idu_stage import rv_decode_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic [31:0] inst_i,
  input  logic [31:0] pc_i,
  input  logic        in_valid_i,
  output logic        in_ready_o,
  input  logic [31:0] rdata1_i,
  input  logic [31:0] rdata2_i,
  output logic [3:0]  rs1_o,
  output logic [3:0]  rs2_o,
  input  logic [15:0] busy_i,
  input  fwd_t        fwd_i,
  output sb_set_t     sb_set_o,
  output decode_out_t out_o,
  output logic        out_valid_o,
  input  logic        out_ready_i
);

  logic [31:0] inst_q;
  logic [31:0] pc_q;
  logic        held_q;
  opcode_e     opcode;
  logic [2:0]  funct3;
  logic [3:0]  rs1;
  logic [3:0]  rs2;
  logic [3:0]  rd;
  logic [31:0] imm;
  logic        fwd1;
  logic        fwd2;
  logic [31:0] rs1_val;
  logic [31:0] rs2_val;
  logic        use_rs1;
  logic        use_rs2;
  logic        hazard;
  logic        accept;
  logic        fire;

  assign opcode = opcode_e'(inst_q[6:0]);
  assign funct3 = inst_q[14:12];
  assign rs1    = inst_q[18:15];  // RV32E, 16 registers
  assign rs2    = inst_q[23:20];
  assign rd     = inst_q[10:7];
  assign rs1_o  = rs1;
  assign rs2_o  = rs2;

  imm_gen u_imm_gen (
    .inst_i (inst_q),
    .imm_o  (imm)
  );

  // Bypass from execute beats the register file
  assign fwd1    = fwd_i.valid && (fwd_i.rd == rs1) && (rs1 != 4'd0);
  assign fwd2    = fwd_i.valid && (fwd_i.rd == rs2) && (rs2 != 4'd0);
  assign rs1_val = (rs1 == 4'd0) ? 32'd0 : (fwd1 ? fwd_i.data : rdata1_i);
  assign rs2_val = (rs2 == 4'd0) ? 32'd0 : (fwd2 ? fwd_i.data : rdata2_i);

  assign use_rs1 = opcode inside {OPC_JALR, OPC_BRANCH, OPC_LOAD, OPC_STORE,
                                  OPC_OP_IMM, OPC_OP, OPC_SYSTEM};
  assign use_rs2 = opcode inside {OPC_BRANCH, OPC_STORE, OPC_OP};

  assign hazard = held_q && ((use_rs1 && busy_i[rs1] && !fwd1) ||
                             (use_rs2 && busy_i[rs2] && !fwd2));

  assign out_valid_o = held_q && !hazard;
  assign fire        = out_valid_o && out_ready_i;
  assign in_ready_o  = !held_q || fire;
  assign accept      = in_valid_i && in_ready_o;

  always_ff @(posedge clk) begin
    if (rst) begin
      held_q <= 1'b0;
    end else if (accept) begin
      held_q <= 1'b1;
    end else if (fire) begin
      held_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      inst_q <= inst_i;
      pc_q   <= pc_i;
    end
  end

  // Claim rd in the scoreboard when it leaves
  assign sb_set_o.valid = fire && out_o.rd_we;
  assign sb_set_o.rd    = rd;

  always_comb begin
    out_o           = '0;
    out_o.opcode    = opcode;
    out_o.alu_op    = ALU_ADD;
    out_o.imm       = imm;
    out_o.rd        = rd;
    out_o.pc        = pc_q;
    out_o.inst      = inst_q;
    out_o.is_system = (opcode == OPC_SYSTEM) || (opcode == OPC_FENCE_I);
    out_o.jump_en   = opcode inside {OPC_JAL, OPC_JALR, OPC_BRANCH, OPC_SYSTEM};
    out_o.rd_we     = (rd != 4'd0) &&
                      (opcode inside {OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR,
                                      OPC_OP_IMM, OPC_OP, OPC_LOAD});
    case (opcode)
      OPC_LUI: begin
        out_o.op2 = imm;
      end
      OPC_AUIPC: begin
        out_o.op1 = pc_q;
        out_o.op2 = imm;
      end
      OPC_JAL: begin
        out_o.op1       = pc_q;
        out_o.op2       = 32'd4;  // Link address
        out_o.jump_base = pc_q;
      end
      OPC_JALR: begin
        out_o.op1       = pc_q;
        out_o.op2       = 32'd4;
        out_o.jump_base = rs1_val;
      end
      OPC_BRANCH: begin
        out_o.op1       = rs1_val;
        out_o.op2       = rs2_val;
        out_o.alu_op    = alu_op_e'({1'b0, funct3});
        out_o.jump_base = pc_q;
      end
      OPC_OP_IMM: begin
        out_o.op1    = rs1_val;
        out_o.op2    = imm;
        out_o.alu_op = alu_op_e'({(funct3 == 3'b101) && inst_q[30], funct3});
      end
      OPC_LOAD: begin
        out_o.op1      = rs1_val;
        out_o.op2      = imm;
        out_o.mem_addr = rs1_val + imm;
        out_o.mem_ren  = 1'b1;
      end
      OPC_STORE: begin
        out_o.op1      = rs1_val;
        out_o.op2      = rs2_val;  // store data
        out_o.mem_addr = rs1_val + imm;
        out_o.mem_wen  = 1'b1;
      end
      OPC_OP: begin
        out_o.op1    = rs1_val;
        out_o.op2    = rs2_val;
        out_o.alu_op = alu_op_e'({inst_q[30], funct3});
      end
      OPC_SYSTEM: begin
        out_o.op1     = rs1_val;
        out_o.csr_wen = ((funct3 == SYS_F3_PRIV) &&
                         ((imm[11:0] == SYS_ECALL) || (imm[11:0] == SYS_MRET))) ||
                        ((funct3 != SYS_F3_PRIV) && (funct3 != SYS_F3_RSVD));
      end
      OPC_FENCE_I: begin
      end
      default: begin
        out_o.illegal = 1'b1;
      end
    endcase
  end

  // Held instruction must not move under back-pressure
  a_hold_stable: assert property (@(posedge clk) disable iff (rst)
    out_valid_o && !out_ready_i |=> $stable(out_o.inst) && $stable(out_o.pc));

endmodule

// ==== hdl/reg_file.sv ====
module reg_file import rv_decode_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic [3:0]  rs1_i,
  input  logic [3:0]  rs2_i,
  output logic [31:0] rdata1_o,
  output logic [31:0] rdata2_o,
  input  wb_t         wb_i
);

  // x0 has no storage
  logic [31:0] regs [1:15];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 16; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_i.valid && (wb_i.rd != 4'd0)) begin
      regs[wb_i.rd] <= wb_i.data;
    end
  end

  // Combinational reads, no write-through
  assign rdata1_o = (rs1_i == 4'd0) ? 32'd0 : regs[rs1_i];
  assign rdata2_o = (rs2_i == 4'd0) ? 32'd0 : regs[rs2_i];

endmodule

// ==== hdl/rf_scoreboard.sv ====
module rf_scoreboard import rv_decode_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  sb_set_t     set_i,
  input  wb_t         wb_i,
  output logic [15:0] busy_o
);

  logic [15:1] busy_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= '0;
    end else begin
      for (int i = 1; i < 16; i++) begin
        if (set_i.valid && (set_i.rd == i[3:0])) begin
          busy_q[i] <= 1'b1;  // Set wins over a same-cycle clear
        end else if (wb_i.valid && (wb_i.rd == i[3:0])) begin
          busy_q[i] <= 1'b0;
        end
      end
    end
  end

  assign busy_o = {busy_q, 1'b0};

  // Decode gates rd_we on rd != 0
  a_no_x0_set: assert property (@(posedge clk) disable iff (rst)
    set_i.valid |-> set_i.rd != 4'd0);

endmodule

// ==== hdl/decode_top.sv ====
module decode_top import rv_decode_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic [31:0] inst_i,
  input  logic [31:0] pc_i,
  input  logic        fetch_valid_i,
  output logic        fetch_ready_o,
  output decode_out_t issue_o,
  output logic        issue_valid_o,
  input  logic        issue_ready_i,
  input  fwd_t        fwd_i,
  input  wb_t         wb_i
);

  logic [3:0]  rs1;
  logic [3:0]  rs2;
  logic [31:0] rdata1;
  logic [31:0] rdata2;
  logic [15:0] busy;
  sb_set_t     sb_set;

  idu_stage u_idu_stage (
    .clk         (clk),
    .rst         (rst),
    .inst_i      (inst_i),
    .pc_i        (pc_i),
    .in_valid_i  (fetch_valid_i),
    .in_ready_o  (fetch_ready_o),
    .rdata1_i    (rdata1),
    .rdata2_i    (rdata2),
    .rs1_o       (rs1),
    .rs2_o       (rs2),
    .busy_i      (busy),
    .fwd_i       (fwd_i),
    .sb_set_o    (sb_set),
    .out_o       (issue_o),
    .out_valid_o (issue_valid_o),
    .out_ready_i (issue_ready_i)
  );

  reg_file u_reg_file (
    .clk      (clk),
    .rst      (rst),
    .rs1_i    (rs1),
    .rs2_i    (rs2),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2),
    .wb_i     (wb_i)
  );

  rf_scoreboard u_rf_scoreboard (
    .clk    (clk),
    .rst    (rst),
    .set_i  (sb_set),
    .wb_i   (wb_i),
    .busy_o (busy)
  );

endmodule

// ==== verification/tb_decode_top.sv ====
module tb_decode_top import rv_decode_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD = 8;
  localparam int N_DECODE   = 17;
  localparam int N_RANDOM   = 60;
  localparam int N_INSTR    = N_DECODE + 4 + N_RANDOM;

  logic        clk = 1'b0;
  logic        rst;
  logic [31:0] inst_i;
  logic [31:0] pc_i;
  logic        fetch_valid_i;
  logic        fetch_ready_o;
  decode_out_t issue_o;
  logic        issue_valid_o;
  logic        issue_ready_i;
  fwd_t        fwd_i;
  wb_t         wb_i;

  integer      seed = 32'hb368b9c3;
  int          errors = 0;
  int          accepted;
  int          issued;
  string       test_name = "reset";
  logic        auto_wb = 1'b0;
  logic        rand_mode = 1'b0;
  logic [31:0] shadow [16];
  logic [15:0] tb_busy;
  logic [63:0] q [$];
  logic        head_valid;
  logic [31:0] head_inst;
  logic [31:0] head_pc;
  logic [3:0]  rs1_idx;
  logic [3:0]  rs2_idx;
  logic [31:0] rv1;
  logic [31:0] rv2;
  logic        use1;
  logic        use2;
  logic        tb_hazard;
  logic        fire;
  decode_out_t expected;
  logic [21:0] ctrl_exp;
  logic [21:0] ctrl_act;

  // lui, auipc, jal, jalr, bne, addi, srai, sub, lw, sw, ecall, mret, ebreak, csrrw,
  // add x0, two undefined opcodes
  logic [31:0] decode_prog [N_DECODE] = '{
    32'h123450b7, 32'hfffff117, 32'hffdff1ef, 32'h01008267, 32'h80209863, 32'hffd08293,
    32'h40315313, 32'h402083b3, 32'h0081a403, 32'hfe912e23, 32'h00000073, 32'h30200073,
    32'h00100073, 32'h30009573, 32'h00300033, 32'hffffffff, 32'h0000000b};
  logic [6:0] rand_opc [10] = '{OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH,
                                OPC_LOAD, OPC_STORE, OPC_OP_IMM, OPC_OP, OPC_SYSTEM};

  decode_top i_dut (
    .clk           (clk),
    .rst           (rst),
    .inst_i        (inst_i),
    .pc_i          (pc_i),
    .fetch_valid_i (fetch_valid_i),
    .fetch_ready_o (fetch_ready_o),
    .issue_o       (issue_o),
    .issue_valid_o (issue_valid_o),
    .issue_ready_i (issue_ready_i),
    .fwd_i         (fwd_i),
    .wb_i          (wb_i)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] imm_of(input logic [31:0] inst);
    logic signed [31:0] simm;
    case (inst[6:0])
      OPC_LUI, OPC_AUIPC: simm = {inst[31:12], 12'h000};
      OPC_JAL: simm = $signed({inst[31], inst[19:12], inst[20], inst[30:21], 1'b0});
      OPC_JALR, OPC_LOAD, OPC_OP_IMM: simm = $signed(inst[31:20]);
      OPC_STORE: simm = $signed({inst[31:25], inst[11:7]});
      OPC_BRANCH: simm = $signed({inst[31], inst[7], inst[30:25], inst[11:8], 1'b0});
      OPC_SYSTEM: simm = {20'h00000, inst[31:20]};  // Zero-extended CSR field
      default: simm = 32'sh0;
    endcase
    return simm;
  endfunction

  // a and b are the source values as the stage should see them
  function automatic decode_out_t model_decode(input logic [31:0] inst, input logic [31:0] pc,
                                               input logic [31:0] a, input logic [31:0] b);
    decode_out_t d;
    logic [2:0]  f3;
    f3 = inst[14:12];
    d = '0;
    d.opcode = opcode_e'(inst[6:0]);
    d.alu_op = ALU_ADD;
    d.imm = imm_of(inst);
    d.rd = inst[10:7];
    d.pc = pc;
    d.inst = inst;
    d.rd_we = (d.rd != 4'd0) && (inst[6:0] inside {OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR,
                                                   OPC_OP_IMM, OPC_OP, OPC_LOAD});
    d.jump_en = inst[6:0] inside {OPC_JAL, OPC_JALR, OPC_BRANCH, OPC_SYSTEM};
    d.is_system = inst[6:0] inside {OPC_SYSTEM, OPC_FENCE_I};
    case (inst[6:0])
      OPC_LUI: d.op2 = d.imm;
      OPC_AUIPC: begin
        d.op1 = pc;
        d.op2 = d.imm;
      end
      OPC_JAL, OPC_JALR: begin
        d.op1 = pc;
        d.op2 = 32'd4;
        d.jump_base = (inst[6:0] == OPC_JAL) ? pc : a;
      end
      OPC_BRANCH: begin
        d.op1 = a;
        d.op2 = b;
        d.alu_op = alu_op_e'({1'b0, f3});
        d.jump_base = pc;
      end
      OPC_OP_IMM: begin
        d.op1 = a;
        d.op2 = d.imm;
        d.alu_op = alu_op_e'({f3 == 3'b101 && inst[30], f3});
      end
      OPC_LOAD, OPC_STORE: begin
        d.op1 = a;
        d.op2 = (inst[6:0] == OPC_LOAD) ? d.imm : b;
        d.mem_addr = a + d.imm;
        d.mem_ren = inst[6:0] == OPC_LOAD;
        d.mem_wen = inst[6:0] == OPC_STORE;
      end
      OPC_OP: begin
        d.op1 = a;
        d.op2 = b;
        d.alu_op = alu_op_e'({inst[30], f3});
      end
      OPC_SYSTEM: begin
        d.op1 = a;
        d.csr_wen = (f3 == 3'b000) ? (inst[31:20] == 12'h000 || inst[31:20] == 12'h302)
                                   : (f3 != 3'b100);
      end
      OPC_FENCE_I: begin
      end
      default: d.illegal = 1'b1;
    endcase
    return d;
  endfunction

  // Reference view of the held instruction
  assign rs1_idx   = head_inst[18:15];
  assign rs2_idx   = head_inst[23:20];
  assign rv1       = (rs1_idx == 4'd0) ? 32'd0 :
                     (fwd_i.valid && fwd_i.rd == rs1_idx) ? fwd_i.data : shadow[rs1_idx];
  assign rv2       = (rs2_idx == 4'd0) ? 32'd0 :
                     (fwd_i.valid && fwd_i.rd == rs2_idx) ? fwd_i.data : shadow[rs2_idx];
  assign use1      = head_inst[6:0] inside {OPC_JALR, OPC_BRANCH, OPC_LOAD, OPC_STORE,
                                            OPC_OP_IMM, OPC_OP, OPC_SYSTEM};
  assign use2      = head_inst[6:0] inside {OPC_BRANCH, OPC_STORE, OPC_OP};
  assign tb_hazard = head_valid &&
                     ((use1 && tb_busy[rs1_idx] && !(fwd_i.valid && fwd_i.rd == rs1_idx)) ||
                      (use2 && tb_busy[rs2_idx] && !(fwd_i.valid && fwd_i.rd == rs2_idx)));
  assign expected  = model_decode(head_inst, head_pc, rv1, rv2);
  assign fire      = issue_valid_o && issue_ready_i;
  assign ctrl_exp  = {expected.opcode, expected.alu_op, expected.rd, expected.rd_we,
                      expected.mem_ren, expected.mem_wen, expected.jump_en,
                      expected.is_system, expected.csr_wen, expected.illegal};
  assign ctrl_act  = {issue_o.opcode, issue_o.alu_op, issue_o.rd, issue_o.rd_we,
                      issue_o.mem_ren, issue_o.mem_wen, issue_o.jump_en,
                      issue_o.is_system, issue_o.csr_wen, issue_o.illegal};

  task automatic report_mismatch(input string field, input logic [95:0] expv,
                                 input logic [95:0] actv);
    errors++;
    $display("MISMATCH %s %s: expected %h actual %h", test_name, field, expv, actv);
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("ERROR in %s: %s", test_name, what);
  endtask

  a_reset_state: assert property (@(posedge clk) $fell(rst) |-> !issue_valid_o && fetch_ready_o)
    else report_failure("stage not idle after reset");
  a_in_order: assert property (@(posedge clk) disable iff (rst)
      fire |-> head_valid && issue_o.inst == head_inst && issue_o.pc == head_pc)
    else report_mismatch("inst/pc", $sampled({head_inst, head_pc}),
                         $sampled({issue_o.inst, issue_o.pc}));
  a_control: assert property (@(posedge clk) disable iff (rst) fire |-> ctrl_act == ctrl_exp)
    else report_mismatch("control", $sampled(ctrl_exp), $sampled(ctrl_act));
  a_operands: assert property (@(posedge clk) disable iff (rst)
      fire |-> {issue_o.op1, issue_o.op2} == {expected.op1, expected.op2})
    else report_mismatch("op1/op2", $sampled({expected.op1, expected.op2}),
                         $sampled({issue_o.op1, issue_o.op2}));
  a_imm_addr: assert property (@(posedge clk) disable iff (rst)
      fire |-> {issue_o.imm, issue_o.mem_addr, issue_o.jump_base} ==
               {expected.imm, expected.mem_addr, expected.jump_base})
    else report_mismatch("imm/mem_addr/jump_base",
                         $sampled({expected.imm, expected.mem_addr, expected.jump_base}),
                         $sampled({issue_o.imm, issue_o.mem_addr, issue_o.jump_base}));
  a_stall: assert property (@(posedge clk) disable iff (rst)
      issue_valid_o == (head_valid && !tb_hazard))
    else report_failure("issue_valid_o disagrees with the busy registers");
  a_hold: assert property (@(posedge clk) disable iff (rst) issue_valid_o && !issue_ready_i
      |=> $stable(issue_o.inst) && $stable(issue_o.pc) && !$past(fetch_ready_o))
    else report_failure("held instruction moved or fetch was ready under back-pressure");

  // Reference queue of accepted instructions
  always @(posedge clk) begin
    if (rst) begin
      q.delete();
      head_valid <= 1'b0;
      accepted   <= 0;
      issued     <= 0;
    end else begin
      if (fire && q.size() != 0) begin
        void'(q.pop_front());
        issued <= issued + 1;
      end
      if (fetch_valid_i && fetch_ready_o) begin
        q.push_back({inst_i, pc_i});
        accepted <= accepted + 1;
      end
      head_valid <= q.size() != 0;
      if (q.size() != 0) begin
        {head_inst, head_pc} <= q[0];
      end
    end
  end

  always @(posedge clk) begin
    if (rst) begin
      tb_busy <= '0;
      for (int j = 0; j < 16; j++) begin
        shadow[j] <= '0;
      end
    end else begin
      if (wb_i.valid) begin
        tb_busy[wb_i.rd] <= 1'b0;
        shadow[wb_i.rd]  <= wb_i.data;
      end
      if (fire && expected.rd_we) begin
        tb_busy[expected.rd] <= 1'b1;  // Claim beats a writeback
      end
    end
  end

  // Background back-pressure, stray bypasses and writebacks of busy registers
  always @(posedge clk) begin
    if (rand_mode) begin
      issue_ready_i <= ($random(seed) & 3) != 0;
      fwd_i <= {($random(seed) & 3) == 0, 4'($random(seed)), 32'($random(seed))};
    end
    if (auto_wb) begin
      wb_i <= '0;
      for (int j = 15; j > 0; j--) begin
        if (tb_busy[j] && ($random(seed) & 1)) begin
          wb_i <= {1'b1, 4'(j), 32'($random(seed))};
        end
      end
    end
  end

  task automatic send(input logic [31:0] inst, input logic [31:0] pc);
    fetch_valid_i <= 1'b1;
    inst_i        <= inst;
    pc_i          <= pc;
    @(posedge clk);
    while (!fetch_ready_o) begin
      @(posedge clk);
    end
    fetch_valid_i <= 1'b0;
  endtask

  task automatic drain(input logic until_idle);
    do begin
      @(posedge clk);
    end while (issued != accepted || (until_idle && tb_busy != 0));
  endtask

  task automatic write_reg(input logic [3:0] rd, input logic [31:0] data);
    wb_i <= {1'b1, rd, data};
    @(posedge clk);
    wb_i <= '0;
  endtask

  initial begin
    logic [31:0] w;
    rst           = 1'b1;
    inst_i        = '0;
    pc_i          = '0;
    fetch_valid_i = 1'b0;
    issue_ready_i = 1'b1;
    fwd_i         = '0;
    wb_i          = '0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < 16; i++) begin
      write_reg(4'(i), $random(seed));  // x0 write must be dropped
    end

    test_name = "decode";
    auto_wb <= 1'b1;
    for (int k = 0; k < N_DECODE; k++) begin
      send(decode_prog[k], 32'h100 + 4 * k);
    end
    drain(1'b1);
    auto_wb <= 1'b0;
    @(posedge clk);

    test_name = "hazard";
    send(32'h00100593, 32'h200);  // addi x11, x0, 1
    send(32'h00158633, 32'h204);  // add x12, x11, x1
    repeat (6) @(posedge clk);
    write_reg(4'd11, 32'hcafe0011);
    drain(1'b0);
    write_reg(4'd12, $random(seed));

    test_name = "forward";
    send(32'h00200693, 32'h300);  // addi x13, x0, 2
    send(32'h40d08733, 32'h304);  // sub x14, x1, x13
    repeat (4) @(posedge clk);
    fwd_i <= {1'b1, 4'd13, 32'h0badf00d};
    drain(1'b0);
    fwd_i <= '0;
    write_reg(4'd13, 32'h0badf00d);
    write_reg(4'd14, $random(seed));

    test_name = "random";
    auto_wb   <= 1'b1;
    rand_mode <= 1'b1;
    for (int k = 0; k < N_RANDOM; k++) begin
      w = $random(seed);
      w[6:0] = rand_opc[$unsigned($random(seed)) % 10];
      w[11] = 1'b0;  // RV32E register fields
      w[19] = 1'b0;
      w[24] = 1'b0;
      send(w, 32'h1000 + 4 * k);
    end
    rand_mode <= 1'b0;
    @(posedge clk);
    issue_ready_i <= 1'b1;
    fwd_i         <= '0;
    drain(1'b1);
    auto_wb <= 1'b0;
    @(posedge clk);

    $display("Done: %0d errors, %0d accepted, %0d issued", errors, accepted, issued);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  initial begin
    #(N_INSTR * 40 * CLK_PERIOD);
    $display("Watchdog expired in %s with %0d of %0d issued", test_name, issued, accepted);
    $display("Regression failed");
    $finish;
  end

endmodule

// ==== filelist.f ====
common/rv_decode_pkg.sv
idu/imm_gen.sv
idu/idu_stage.sv
hdl/reg_file.sv
hdl/rf_scoreboard.sv
hdl/decode_top.sv
verification/tb_decode_top.sv

// ==== Bender.yml ====
package:
  name: rv32e_decode

sources:
  - common/rv_decode_pkg.sv
  - idu/imm_gen.sv
  - idu/idu_stage.sv
  - hdl/reg_file.sv
  - hdl/rf_scoreboard.sv
  - hdl/decode_top.sv
  - target: simulation
    files:
      - verification/tb_decode_top.sv
